// ==== dv/l1cache_checker.sv ====
`timescale 1ns/1ps

module l1cache_checker
  ( input logic clk
  , input logic reset
  , input logic read
  , input logic write
  , input logic core_resp
  , input logic mem_read
  , input logic mem_write
  , input logic mem_resp
  );

  // one memory op at a time
  mem_ops_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(mem_read && mem_write))
    else $error("mem_read and mem_write high together");

  mem_read_held: assert property (@(posedge clk) disable iff (reset)
    mem_read && !mem_resp |=> mem_read)
    else $error("mem_read dropped before mem_resp");

  mem_write_held: assert property (@(posedge clk) disable iff (reset)
    mem_write && !mem_resp |=> mem_write)
    else $error("mem_write dropped before mem_resp");

  // no response without a request
  resp_needs_req: assert property (@(posedge clk) disable iff (reset)
    core_resp |-> (read || write))
    else $error("core_resp high with no core request");

endmodule : l1cache_checker

// ==== dv/l1cache_mem_model.sv ====
`timescale 1ns/1ps

module l1cache_mem_model
  #(parameter l1cache_pkg::word_t FILL_XOR = 32'h0)
  ( input  logic               clk
  , input  logic               reset
  , input  logic               mem_read
  , input  logic               mem_write
  , input  l1cache_pkg::addr_t mem_addr
  , input  l1cache_pkg::line_t mem_wdata
  , output l1cache_pkg::line_t mem_rdata = '0
  , output logic               mem_resp = 1'b0
  );

  import l1cache_pkg::*;

  localparam logic [31:0] LFSR_SEED = 32'he853_9cc4;

  line_t       store [addr_t];  // only lines written back
  logic [31:0] lfsr = LFSR_SEED;
  logic [2:0]  lat;
  logic [2:0]  wait_cnt;
  logic        busy;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic line_t initial_line(addr_t line_addr);
    line_t l;
    for (int w = 0; w < LINE_WORDS; w++) begin
      l[w] = (line_addr + addr_t'(4 * w)) ^ FILL_XOR;
    end
    return l;
  endfunction

  function automatic line_t stored_line(addr_t line_addr);
    if (store.exists(line_addr)) begin
      return store[line_addr];
    end
    return initial_line(line_addr);
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      mem_resp  <= 1'b0;
      mem_rdata <= '0;
      busy      <= 1'b0;
      wait_cnt  <= '0;
    end else if (mem_resp) begin
      mem_resp <= 1'b0;  // single-cycle pulse
      busy     <= 1'b0;
    end else if (mem_read || mem_write) begin
      if (!busy) begin
        for (int i = 0; i < 3; i++) begin
          lfsr   = lfsr_next(lfsr);
          lat[i] = lfsr[0];
        end
        busy     <= 1'b1;
        wait_cnt <= lat;
      end else if (wait_cnt != 3'd0) begin
        wait_cnt <= wait_cnt - 3'd1;
      end else begin
        if (mem_write) begin
          store[mem_addr] = mem_wdata;
        end else begin
          mem_rdata <= stored_line(mem_addr);
        end
        mem_resp <= 1'b1;
      end
    end
  end

endmodule : l1cache_mem_model

// ==== dv/l1cache_tb.sv ====
`timescale 1ns/1ps

module l1cache_tb;

  import l1cache_pkg::*;

  localparam word_t FILL_XOR       = 32'h5a5a_c3c3;
  localparam int    TIMEOUT_CYCLES = 100;

  typedef struct packed {
    logic  is_write;
    addr_t addr;
    word_t wdata;
    mask_t wmask;
    logic  exp_miss;
    logic  exp_wb;
    addr_t wb_addr;  // victim line, when exp_wb
  } req_t;

  logic  clk = 1'b0;
  logic  reset;
  logic  read;
  logic  write;
  addr_t addr;
  word_t wdata;
  mask_t wmask;
  word_t rdata;
  logic  core_resp;
  logic  mem_read;
  logic  mem_write;
  addr_t mem_addr;
  line_t mem_wdata;
  line_t mem_rdata;
  logic  mem_resp;

  req_t        stim [$];
  word_t       shadow [addr_t];
  int          step;
  logic        passed = 1'b0;
  logic        fail_reported = 1'b0;
  int unsigned mem_reads = 0;
  int unsigned mem_writes = 0;
  int unsigned mem_events = 0;
  int unsigned rd_seq = 0;
  int unsigned wb_seq = 0;
  addr_t       last_wb_addr = '0;
  addr_t       last_rd_addr = '0;
  line_t       last_wb_line = '0;

  always #20 clk = ~clk;

  l1cache DUT (
    .clk       (clk),
    .reset     (reset),
    .read      (read),
    .write     (write),
    .addr      (addr),
    .wdata     (wdata),
    .wmask     (wmask),
    .rdata     (rdata),
    .core_resp (core_resp),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .mem_resp  (mem_resp)
  );

  l1cache_mem_model #(
    .FILL_XOR (FILL_XOR)
  ) mem (
    .clk       (clk),
    .reset     (reset),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .mem_resp  (mem_resp)
  );

  bind l1cache l1cache_checker protocol_check (
    .clk       (clk),
    .reset     (reset),
    .read      (read),
    .write     (write),
    .core_resp (core_resp),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_resp  (mem_resp)
  );

  // completed memory transfers, in order
  always @(posedge clk) begin
    if (mem_resp && mem_read) begin
      mem_reads    <= mem_reads + 1;
      rd_seq       <= mem_events;
      last_rd_addr <= mem_addr;
      mem_events   <= mem_events + 1;
    end else if (mem_resp && mem_write) begin
      mem_writes   <= mem_writes + 1;
      wb_seq       <= mem_events;
      last_wb_addr <= mem_addr;
      last_wb_line <= mem_wdata;
      mem_events   <= mem_events + 1;
    end
  end

  task automatic report_failure(string why);
    fail_reported = 1'b1;
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
    if (got !== expected) begin
      report_failure($sformatf("CHECK FAILED at %0t: step %0d %s got %h expected %h",
                               $time, step, name, got, expected));
    end
  endtask

  function automatic word_t expected_word(addr_t a);
    addr_t wa;
    wa = {a[ADDR_W-1:2], 2'b00};
    if (shadow.exists(wa)) begin
      return shadow[wa];
    end
    return wa ^ FILL_XOR;  // untouched memory pattern
  endfunction

  task automatic apply_write(addr_t a, word_t d, mask_t m);
    addr_t wa;
    word_t w;
    wa = {a[ADDR_W-1:2], 2'b00};
    w  = expected_word(wa);
    for (int b = 0; b < WORD_W / 8; b++) begin
      if (m[b]) begin
        w[8*b +: 8] = d[8*b +: 8];
      end
    end
    shadow[wa] = w;
  endtask

  task automatic add_step(logic is_write, addr_t a, word_t d, mask_t m,
                          logic miss, logic wb, addr_t wb_addr);
    stim.push_back('{is_write, a, d, m, miss, wb, wb_addr});
  endtask

  task automatic build_table();
    // wr  addr          wdata          mask     miss  wb    victim line
    add_step(1'b0, 32'h0000_0004, 32'h0, 4'b0000, 1'b1, 1'b0, 32'h0);
    add_step(1'b0, 32'h0000_1020, 32'h0, 4'b0000, 1'b1, 1'b0, 32'h0);  // line A, set 2
    add_step(1'b0, 32'h0000_1024, 32'h0, 4'b0000, 1'b0, 1'b0, 32'h0);
    add_step(1'b1, 32'h0000_1028, 32'hdead_beef, 4'b0101, 1'b0, 1'b0, 32'h0);
    add_step(1'b0, 32'h0000_1028, 32'h0, 4'b0000, 1'b0, 1'b0, 32'h0);
    add_step(1'b0, 32'h0000_2020, 32'h0, 4'b0000, 1'b1, 1'b0, 32'h0);  // line B
    add_step(1'b0, 32'h0000_1020, 32'h0, 4'b0000, 1'b0, 1'b0, 32'h0);
    add_step(1'b0, 32'h0000_3020, 32'h0, 4'b0000, 1'b1, 1'b0, 32'h0);  // C evicts B
    add_step(1'b0, 32'h0000_102c, 32'h0, 4'b0000, 1'b0, 1'b0, 32'h0);
    add_step(1'b0, 32'h0000_2024, 32'h0, 4'b0000, 1'b1, 1'b0, 32'h0);
    add_step(1'b0, 32'h0000_4020, 32'h0, 4'b0000, 1'b1, 1'b1, 32'h0000_1020);
    add_step(1'b0, 32'h0000_1028, 32'h0, 4'b0000, 1'b1, 1'b0, 32'h0);  // written data back
    add_step(1'b1, 32'h0000_5034, 32'h1234_5678, 4'b1111, 1'b1, 1'b0, 32'h0);  // set 3
    add_step(1'b0, 32'h0000_5034, 32'h0, 4'b0000, 1'b0, 1'b0, 32'h0);
    add_step(1'b1, 32'h0000_50b4, 32'ha5a5_0f0f, 4'b1000, 1'b1, 1'b0, 32'h0);
    add_step(1'b1, 32'h0000_51b4, 32'h0bad_cafe, 4'b0011, 1'b1, 1'b1, 32'h0000_5030);
    add_step(1'b0, 32'h0000_5034, 32'h0, 4'b0000, 1'b1, 1'b1, 32'h0000_50b0);
    add_step(1'b0, 32'h0000_51b4, 32'h0, 4'b0000, 1'b0, 1'b0, 32'h0);
    add_step(1'b0, 32'h0000_50b4, 32'h0, 4'b0000, 1'b1, 1'b0, 32'h0);  // evicts clean 5030
    add_step(1'b0, 32'h0000_51b4, 32'h0, 4'b0000, 1'b0, 1'b0, 32'h0);
    add_step(1'b0, 32'hffff_fff4, 32'h0, 4'b0000, 1'b1, 1'b0, 32'h0);  // set 7, tag all ones
    add_step(1'b0, 32'hffff_fff8, 32'h0, 4'b0000, 1'b0, 1'b0, 32'h0);
    add_step(1'b1, 32'h0000_0008, 32'h7e57_00aa, 4'b0010, 1'b0, 1'b0, 32'h0);
    add_step(1'b0, 32'h0000_0008, 32'h0, 4'b0000, 1'b0, 1'b0, 32'h0);
  endtask

  // entered 2 ns after a rising edge, leaves the same way
  task automatic run_request(req_t r);
    int unsigned rd0;
    int unsigned wb0;
    int          cycles;
    rd0    = mem_reads;
    wb0    = mem_writes;
    cycles = 0;
    read   = !r.is_write;
    write  = r.is_write;
    addr   = r.addr;
    wdata  = r.wdata;
    wmask  = r.wmask;
    @(negedge clk);
    while (!core_resp) begin
      if (cycles >= TIMEOUT_CYCLES) begin
        report_failure($sformatf("timeout: step %0d at address %h never got core_resp",
                                 step, r.addr));
      end else begin
        cycles++;
        @(negedge clk);
      end
    end
    check_value("mem_read count", mem_reads - rd0, 32'(r.exp_miss));
    check_value("mem_write count", mem_writes - wb0, 32'(r.exp_wb));
    if (r.exp_miss) begin
      check_value("fill mem_addr", last_rd_addr,
                  {r.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
    end
    if (r.exp_wb) begin
      check_value("mem_addr", last_wb_addr, r.wb_addr);
      for (int w = 0; w < LINE_WORDS; w++) begin
        check_value("mem_wdata", last_wb_line[w], expected_word(r.wb_addr + addr_t'(4 * w)));
      end
      check_value("mem_write before mem_read", 32'(wb_seq < rd_seq), 32'd1);
    end
    if (!r.exp_miss) begin
      check_value("core_resp latency", cycles, 32'd0);
    end
    if (r.is_write) begin
      apply_write(r.addr, r.wdata, r.wmask);
    end else begin
      check_value("rdata", rdata, expected_word(r.addr));
    end
    @(posedge clk);
    #2;
    read  = 1'b0;
    write = 1'b0;
  endtask

  initial begin
    reset = 1'b1;
    read  = 1'b0;
    write = 1'b0;
    addr  = '0;
    wdata = '0;
    wmask = '0;
    step  = -1;
    build_table();
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    @(negedge clk);
    check_value("core_resp", 32'(core_resp), 32'd0);
    check_value("mem_read", 32'(mem_read), 32'd0);
    check_value("mem_write", 32'(mem_write), 32'd0);
    @(posedge clk);
    #2;
    for (int i = 0; i < stim.size(); i++) begin
      step = i;
      run_request(stim[i]);
    end
    passed = 1'b1;
    $display("sim passed");
    $finish;
  end

  // run stopped some other way, e.g. by an assertion
  final begin
    if (!passed && !fail_reported) begin
      $display("sim failed");
    end
  end

endmodule : l1cache_tb

// ==== hw/l1cache.sv ====
`timescale 1ns/1ps

module l1cache
  ( input  logic               clk
  , input  logic               reset

  // core side
  , input  logic               read
  , input  logic               write
  , input  l1cache_pkg::addr_t addr
  , input  l1cache_pkg::word_t wdata
  , input  l1cache_pkg::mask_t wmask
  , output l1cache_pkg::word_t rdata
  , output logic               core_resp

  // memory side, one line per transfer
  , output logic               mem_read
  , output logic               mem_write
  , output l1cache_pkg::addr_t mem_addr
  , output l1cache_pkg::line_t mem_wdata
  , input  l1cache_pkg::line_t mem_rdata
  , input  logic               mem_resp
  );

  logic hit;
  logic dirty;
  logic nmru_update;
  logic cacheline_write;
  logic cacheline_allocate;
  logic dirtytag_sel;
  logic cacheline_data_sel;

  l1cache_control control (
    .clk                (clk),
    .reset              (reset),
    .read               (read),
    .write              (write),
    .core_resp          (core_resp),
    .mem_read           (mem_read),
    .mem_write          (mem_write),
    .mem_resp           (mem_resp),
    .hit                (hit),
    .dirty              (dirty),
    .nmru_update        (nmru_update),
    .cacheline_write    (cacheline_write),
    .cacheline_allocate (cacheline_allocate),
    .dirtytag_sel       (dirtytag_sel),
    .cacheline_data_sel (cacheline_data_sel)
  );

  l1cache_datapath datapath (
    .clk                (clk),
    .reset              (reset),
    .addr               (addr),
    .wdata              (wdata),
    .wmask              (wmask),
    .rdata              (rdata),
    .mem_addr           (mem_addr),
    .mem_wdata          (mem_wdata),
    .mem_rdata          (mem_rdata),
    .hit                (hit),
    .dirty              (dirty),
    .nmru_update        (nmru_update),
    .cacheline_write    (cacheline_write),
    .cacheline_allocate (cacheline_allocate),
    .dirtytag_sel       (dirtytag_sel),
    .cacheline_data_sel (cacheline_data_sel)
  );

endmodule : l1cache

// ==== hw/l1cache_array.sv ====
`timescale 1ns/1ps

// one entry per set, read is combinational
module l1cache_array
  #(parameter type entry_t = logic [31:0])
  ( input  logic                clk
  , input  l1cache_pkg::index_t index
  , input  logic                we
  , input  entry_t              wentry
  , output entry_t              rentry
  );

  import l1cache_pkg::*;

  entry_t mem [NUM_SETS];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[index] <= wentry;
    end
  end

  assign rentry = mem[index];  // same-set read, no latency

endmodule : l1cache_array

// ==== hw/l1cache_control.sv ====
`timescale 1ns/1ps

module l1cache_control
  ( input  logic clk
  , input  logic reset

  , input  logic read
  , input  logic write
  , output logic core_resp

  , output logic mem_read
  , output logic mem_write
  , input  logic mem_resp

  , input  logic hit
  , input  logic dirty
  , output logic nmru_update
  , output logic cacheline_write
  , output logic cacheline_allocate
  , output logic dirtytag_sel
  , output logic cacheline_data_sel
  );

  typedef enum logic [1:0] {
    idle,
    allocate,
    writeback
  } state_t;

  state_t state;
  state_t next_state;
  logic   req;

  assign req = read || write;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    core_resp          = 1'b0;
    mem_read           = 1'b0;
    mem_write          = 1'b0;
    nmru_update        = 1'b0;
    cacheline_write    = 1'b0;
    cacheline_allocate = 1'b0;
    dirtytag_sel       = 1'b0;
    cacheline_data_sel = 1'b0;
    next_state         = state;

    case (state)
      idle: begin
        if (req) begin
          if (hit) begin
            // zero-latency hit
            core_resp       = 1'b1;
            nmru_update     = 1'b1;
            cacheline_write = write;
          end else if (dirty) begin
            mem_write    = 1'b1;
            dirtytag_sel = 1'b1;
            next_state   = writeback;
          end else begin
            mem_read           = 1'b1;
            cacheline_data_sel = 1'b1;
            next_state         = allocate;
          end
        end
      end

      allocate: begin
        mem_read           = 1'b1;  // held through the resp cycle
        cacheline_data_sel = 1'b1;
        if (mem_resp) begin
          cacheline_allocate = 1'b1;
          next_state         = idle;  // request replays as a hit
        end
      end

      writeback: begin
        mem_write    = 1'b1;
        dirtytag_sel = 1'b1;
        if (mem_resp) begin
          next_state = allocate;
        end
      end

      default: begin
        next_state = idle;
      end
    endcase
  end

endmodule : l1cache_control

// ==== hw/l1cache_datapath.sv ====
`timescale 1ns/1ps

module l1cache_datapath
  ( input  logic               clk
  , input  logic               reset

  , input  l1cache_pkg::addr_t addr
  , input  l1cache_pkg::word_t wdata
  , input  l1cache_pkg::mask_t wmask
  , output l1cache_pkg::word_t rdata

  , output l1cache_pkg::addr_t mem_addr
  , output l1cache_pkg::line_t mem_wdata
  , input  l1cache_pkg::line_t mem_rdata

  , output logic               hit
  , output logic               dirty
  , input  logic               nmru_update
  , input  logic               cacheline_write
  , input  logic               cacheline_allocate
  , input  logic               dirtytag_sel
  , input  logic               cacheline_data_sel
  );

  import l1cache_pkg::*;

  localparam int WOFF_W = $clog2(LINE_WORDS);
  localparam int BYTES  = WORD_W / 8;

  // request fields
  tag_t              tag;
  index_t            index;
  logic [WOFF_W-1:0] word_off;

  // per-way array outputs and enables
  tag_t       way_tag  [2];
  line_t      way_line [2];
  logic [1:0] way_hit;
  logic [1:0] tag_we;
  logic [1:0] data_we;

  // per-set state bits
  logic [1:0][NUM_SETS-1:0] valid_q;
  logic [1:0][NUM_SETS-1:0] dirty_q;
  logic [NUM_SETS-1:0]      nmru_q;

  logic  hit_way;
  logic  victim;
  line_t hit_line;
  line_t merged_line;
  line_t fill_line;

  assign tag      = addr[ADDR_W-1 -: TAG_W];
  assign index    = addr[OFFSET_W +: INDEX_W];
  assign word_off = addr[OFFSET_W-1 -: WOFF_W];  // byte bits dropped

  for (genvar w = 0; w < 2; w++) begin : g_way
    assign way_hit[w] = valid_q[w][index] && (way_tag[w] == tag);

    // tag only changes on a fill
    assign tag_we[w]  = cacheline_allocate && (victim == 1'(w));
    assign data_we[w] = tag_we[w] || (cacheline_write && hit && (hit_way == 1'(w)));

    l1cache_array #(
      .entry_t (tag_t)
    ) tag_array (
      .clk    (clk),
      .index  (index),
      .we     (tag_we[w]),
      .wentry (tag),
      .rentry (way_tag[w])
    );

    l1cache_array #(
      .entry_t (line_t)
    ) data_array (
      .clk    (clk),
      .index  (index),
      .we     (data_we[w]),
      .wentry (fill_line),
      .rentry (way_line[w])
    );
  end

  assign hit      = |way_hit;
  assign hit_way  = way_hit[1];      // way 0 unless way 1 matches
  assign hit_line = way_line[hit_way];
  assign rdata    = hit_line[word_off];

  // victim is whatever the nmru bit names
  assign victim = nmru_q[index];
  assign dirty  = valid_q[victim][index] && dirty_q[victim][index];

  // byte merge of the store into the hit line
  always_comb begin
    merged_line = hit_line;
    for (int b = 0; b < BYTES; b++) begin
      if (wmask[b]) begin
        merged_line[word_off][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  end

  assign fill_line = cacheline_data_sel ? mem_rdata : merged_line;

  // writeback goes to the victim's address, fills to the request's line
  assign mem_addr  = {(dirtytag_sel ? way_tag[victim] : tag), index, {OFFSET_W{1'b0}}};
  assign mem_wdata = way_line[victim];

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
      nmru_q  <= '0;
    end else begin
      if (cacheline_allocate) begin
        valid_q[victim][index] <= 1'b1;
        dirty_q[victim][index] <= 1'b0;  // fresh line from memory
      end
      if (cacheline_write && hit) begin
        dirty_q[hit_way][index] <= 1'b1;
      end
      // point away from the way just used
      if (nmru_update && hit) begin
        nmru_q[index] <= ~hit_way;
      end
    end
  end

endmodule : l1cache_datapath

// ==== hw/l1cache_pkg.sv ====
package l1cache_pkg;

  // geometry
  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;
  localparam int LINE_WORDS = 4;
  localparam int NUM_SETS   = 8;

  localparam int OFFSET_W = $clog2(LINE_WORDS * WORD_W / 8);  // byte offset in a line
  localparam int INDEX_W  = $clog2(NUM_SETS);
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [WORD_W/8-1:0] mask_t;  // one enable per byte
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;

  // word 0 sits in the low bits
  typedef word_t [LINE_WORDS-1:0] line_t;

endpackage : l1cache_pkg

// ==== l1cache.f ====
hw/l1cache_pkg.sv
hw/l1cache_array.sv
hw/l1cache_datapath.sv
hw/l1cache_control.sv
hw/l1cache.sv
dv/l1cache_checker.sv
dv/l1cache_mem_model.sv
dv/l1cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
  -f l1cache.f \
  --top-module l1cache_tb \
  -Mdir "$OBJ" \
  -o l1cache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/l1cache_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
  echo "FAIL: see $LOG"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "FAIL: simulator exited with status $run_status"
  exit 1
fi

echo "PASS"
exit 0
